/* build.f */
mapper_pkg.sv
rom_bus_if.sv
rom_loader.sv
bank_regs.sv
rom_addr_map.sv
mem_port_arb.sv
mapper_top.sv
mapper_sva.sv
tb_mapper.sv

/* Makefile */
# Verilator build and run for the cartridge mapper testbench

SIM = obj_dir/Vtb_mapper

$(SIM): build.f $(wildcard *.sv)
	verilator --binary --assert --top-module tb_mapper -f build.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb_mapper.sv */
//////////////////////////////////////////////////
// Testbench for the cartridge ROM bank mapper
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_mapper;
	import mapper_pkg::*;

	logic clk_sys, reset, dl_active, dl_wr, dl_wait;
	logic [23:0] dl_addr;
	word_t dl_data, cpu_rdata, mem_wdata;
	logic psel, penable, pwrite, pready, pslverr;
	logic [APB_ADDR_W-1:0] paddr;
	bank_t pwdata, prdata;
	logic cpu_rd, cpu_ready, mem_rd, mem_wr;
	cpu_addr_t cpu_addr;
	mem_addr_t mem_addr;
	word_t mem_rdata = '0; // Driven by the memory model
	logic mem_ack = 1'b0;

	word_t mem_data [mem_addr_t]; // Written words
	logic [31:0] lfsr = 32'h011a_cbef;
	bank_t shadow_banks [NUM_BANKS];
	rom_mask_t shadow_mask;
	int cycles = 0;
	int words_sent = 0;
	int writes_done = 0;
	int wait_cnt = 0;

	mapper_top dut_i (.*);

	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Unwritten words follow from the whole address
	function automatic word_t model_word(input mem_addr_t a);
		return mem_data.exists(a) ? mem_data[a] : (a[15:0] ^ {a[22:16], a[22:14]});
	endfunction

	function automatic mem_addr_t expect_addr(input cpu_addr_t c);
		return {shadow_banks[c[20:18]], c[17:0]} & {shadow_mask, 12'hfff};
	endfunction

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= 4000)
			stop_on_error("Timeout: the tests did not finish within 4000 cycles");
		else if (dut_i.sva_i.errors != 0)
			stop_on_error("A handshake assertion failed");
	end

	//////////////////////////////////////////////////
	// Memory model answering in 1 to 6 cycles
	//////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		mem_ack = 1'b0;
		if ((mem_rd || mem_wr) && !reset) begin
			if (wait_cnt == 0)
				wait_cnt = 1 + int'(lfsr_take(3) % 6);
			wait_cnt--;
			if (wait_cnt == 0) begin
				mem_ack = 1'b1;
				if (mem_wr) begin
					mem_data[mem_addr] = mem_wdata;
					writes_done++;
				end else begin
					mem_rdata = model_word(mem_addr);
				end
			end
		end
	end

	task automatic dl_word(input logic [23:0] a, input word_t d);
		@(negedge clk_sys);
		while (dl_wait) @(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		if (a == '0) shadow_mask = '0; // Fresh image
		else shadow_mask |= a[23:13];
		words_sent++;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		while (!mem_wr) @(negedge clk_sys);
		assert (mem_addr == a[23:1] && mem_wdata == {d[7:0], d[15:8]})
			else stop_on_error($sformatf("MISMATCH at %0t: write %h/%h for byte address %h",
				$time, mem_addr, mem_wdata, a));
		while (dl_wait) @(negedge clk_sys);
		assert (writes_done == words_sent)
			else stop_on_error($sformatf("MISMATCH at %0t: %0d writes for %0d words",
				$time, writes_done, words_sent));
	endtask

	task automatic cpu_read(input cpu_addr_t c);
		mem_addr_t ea;
		word_t ew;
		@(negedge clk_sys);
		ea = expect_addr(c);
		cpu_addr = c;
		cpu_rd = 1'b1;
		while (!mem_rd) @(negedge clk_sys);
		// Loader write must already be done
		assert (mem_addr == ea && writes_done == words_sent)
			else stop_on_error($sformatf("MISMATCH at %0t: read of %h went to %h, expected %h",
				$time, c, mem_addr, ea));
		ew = model_word(ea);
		while (!cpu_ready) @(negedge clk_sys);
		assert (cpu_rdata == ew)
			else stop_on_error($sformatf("MISMATCH at %0t: cpu_rdata %h, expected %h",
				$time, cpu_rdata, ew));
		cpu_rd = 1'b0;
	endtask

	task automatic apb_access(input logic wr, input logic [2:0] idx, input bank_t v,
			input logic expect_err);
		@(negedge clk_sys);
		psel = 1'b1;
		pwrite = wr;
		paddr = {idx, 1'b0};
		pwdata = v;
		@(negedge clk_sys);
		penable = 1'b1;
		@(posedge clk_sys);
		assert (pready && pslverr == expect_err && (wr || prdata == shadow_banks[idx]))
			else stop_on_error($sformatf("MISMATCH at %0t: bank %0d access, pslverr %b prdata %h",
				$time, idx, pslverr, prdata));
		@(negedge clk_sys);
		psel = 1'b0;
		penable = 1'b0;
		if (wr && !expect_err) shadow_banks[idx] = v;
	endtask

	task automatic set_download(input logic on);
		@(negedge clk_sys);
		dl_active = on;
		for (int i = 0; i < NUM_BANKS; i++) shadow_banks[i] = bank_t'(i);
		if (!on) repeat (3) @(negedge clk_sys); // Let loading settle
	endtask

	task automatic read_all_banks();
		for (int k = 0; k < NUM_BANKS; k++) begin
			apb_access(1'b0, 3'(k), '0, 1'b0);
			cpu_read({2'b00, 3'(k), 18'(18'h0_0a0 + k * 37)});
		end
	endtask

	initial begin
		{reset, dl_active, dl_wr, dl_addr, dl_data} = {1'b1, 42'd0};
		{psel, penable, pwrite, paddr, pwdata} = '0;
		{cpu_rd, cpu_addr} = '0;
		shadow_mask = '0;
		for (int i = 0; i < NUM_BANKS; i++) shadow_banks[i] = bank_t'(i);
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		read_all_banks(); // Identity after reset

		// Small ROM refuses bank writes
		set_download(1'b1);
		dl_word(24'h00_0000, 16'h1234);
		dl_word(24'h00_1002, 16'hbeef);
		dl_word(24'h3f_fffe, 16'h55aa);
		set_download(1'b0);
		read_all_banks();
		apb_access(1'b1, 3'd3, 5'd9, 1'b1);
		read_all_banks();

		// Large ROM opens banks 1 to 7
		set_download(1'b1);
		dl_word(24'h00_0000, 16'h0f0f);
		dl_word(24'h7f_fffe, 16'ha5c3);
		set_download(1'b0);
		for (int k = 1; k < NUM_BANKS; k++) apb_access(1'b1, 3'(k), 5'(8 + k), 1'b0);
		apb_access(1'b1, 3'd0, 5'd3, 1'b1);
		read_all_banks();

		// New download with a competing CPU read
		set_download(1'b1);
		dl_word(24'h00_0000, 16'h4321);
		fork
			dl_word(24'h00_0010, 16'h8001);
			cpu_read(23'h00_0100);
		join
		set_download(1'b0);
		read_all_banks();

		if (dut_i.sva_i.errors == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			stop_on_error("Handshake assertion failed during the run");
		end
	end

endmodule

`default_nettype wire

/* mapper_sva.sv */
//////////////////////////////////////////////////
// Handshake checks for the cartridge mapper
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mapper_sva (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  dl_active,
	input logic                  dl_wr,
	input logic                  dl_wait,
	input logic                  mem_rd,
	input logic                  mem_wr,
	input logic                  mem_ack,
	input logic                  cpu_ready,
	input mapper_pkg::mem_addr_t mem_addr
);

	int errors = 0; // Failed assertions so far

	// Host stalled on the cycle after a strobe
	wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		dl_active && dl_wr && !dl_wait |=> dl_wait)
		else begin $error("dl_wait did not rise after dl_wr"); errors++; end

	// Release one cycle after the arbiter passes the ack on
	wait_fall: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_wait) |-> $past(mem_ack, 2))
		else begin $error("dl_wait fell without a memory ack"); errors++; end

	//////////////////////////////////////////////////
	// One memory command held until its ack and dropped after it
	//////////////////////////////////////////////////
	cmd_held: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_rd || mem_wr) && !mem_ack |=> (mem_rd || mem_wr) && $stable(mem_addr))
		else begin $error("memory command changed before ack"); errors++; end

	cmd_drop: assert property (@(posedge clk_sys) disable iff (reset)
		mem_ack |=> !mem_rd && !mem_wr)
		else begin $error("memory command still up after ack"); errors++; end

	ready_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_ready |=> !cpu_ready)
		else begin $error("cpu_ready longer than one cycle"); errors++; end

endmodule

bind mapper_top mapper_sva sva_i (.*);

`default_nettype wire

/* mapper_top.sv */
//////////////////////////////////////////////////
// Cartridge ROM bank mapper top level
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mapper_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	// Download stream
	input  logic                              dl_active,
	input  logic                              dl_wr,
	input  logic [23:0]                       dl_addr,
	input  mapper_pkg::word_t                 dl_data,
	output logic                              dl_wait,
	// Page register window
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [mapper_pkg::APB_ADDR_W-1:0] paddr,
	input  mapper_pkg::bank_t                 pwdata,
	output mapper_pkg::bank_t                 prdata,
	output logic                              pready,
	output logic                              pslverr,
	// CPU ROM reads
	input  logic                              cpu_rd,
	input  mapper_pkg::cpu_addr_t             cpu_addr,
	output mapper_pkg::word_t                 cpu_rdata,
	output logic                              cpu_ready,
	// External memory
	output logic                              mem_rd,
	output logic                              mem_wr,
	output mapper_pkg::mem_addr_t             mem_addr,
	output mapper_pkg::word_t                 mem_wdata,
	input  mapper_pkg::word_t                 mem_rdata,
	input  logic                              mem_ack
);
	import mapper_pkg::*;

	rom_mask_t  rom_mask;
	logic       loading;
	bank_file_t banks;

	rom_bus_if load_bus ();
	rom_bus_if read_bus ();

	rom_loader loader_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_active(dl_active),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.dl_wait  (dl_wait),
		.load_bus (load_bus.client),
		.rom_mask (rom_mask),
		.loading  (loading)
	);

	bank_regs regs_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.rom_mask(rom_mask),
		.loading (loading),
		.banks   (banks)
	);

	rom_addr_map map_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_rd   (cpu_rd),
		.cpu_addr (cpu_addr),
		.cpu_rdata(cpu_rdata),
		.cpu_ready(cpu_ready),
		.banks    (banks),
		.rom_mask (rom_mask),
		.read_bus (read_bus.client)
	);

	mem_port_arb arb_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.load_bus (load_bus.port),
		.read_bus (read_bus.port),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack  (mem_ack)
	);

endmodule

`default_nettype wire

/* mem_port_arb.sv */
//////////////////////////////////////////////////
// External memory port arbiter
// Loader first, one command in flight
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mem_port_arb (
	input  logic                  clk_sys,
	input  logic                  reset,
	rom_bus_if.port               load_bus,
	rom_bus_if.port               read_bus,
	output logic                  mem_rd,
	output logic                  mem_wr,
	output mapper_pkg::mem_addr_t mem_addr,
	output mapper_pkg::word_t     mem_wdata,
	input  mapper_pkg::word_t     mem_rdata,
	input  logic                  mem_ack
);
	import mapper_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t    state;
	logic      gnt_load; // Owner of the current command
	logic      ack_q;
	word_t     rdata_q;
	logic      take;
	logic      sel_we;
	mem_addr_t sel_addr;
	word_t     sel_wdata;

	// Client holds req through its ack cycle, so skip that cycle
	assign take = (state == ST_IDLE) & ~ack_q & (load_bus.req | read_bus.req);

	assign sel_we = load_bus.req ? load_bus.we : read_bus.we;
	assign sel_addr = load_bus.req ? load_bus.addr : read_bus.addr;
	assign sel_wdata = load_bus.req ? load_bus.wdata : read_bus.wdata;

	//////////////////////////////////////////////////
	// Grant FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			gnt_load <= 1'b0;
			ack_q <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			case (state)
				ST_IDLE: if (take) begin
					gnt_load <= load_bus.req;
					mem_rd <= ~sel_we;
					mem_wr <= sel_we;
					state <= ST_BUSY;
				end
				ST_BUSY: if (mem_ack) begin
					mem_rd <= 1'b0;
					mem_wr <= 1'b0;
					ack_q <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command and read word
	always_ff @(posedge clk_sys) begin
		if (take) begin
			mem_addr <= sel_addr;
			mem_wdata <= sel_wdata;
		end
		if (state == ST_BUSY && mem_ack) begin
			rdata_q <= mem_rdata;
		end
	end

	assign load_bus.ack = ack_q & gnt_load;
	assign read_bus.ack = ack_q & ~gnt_load;
	assign load_bus.rdata = rdata_q;
	assign read_bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* rom_addr_map.sv */
//////////////////////////////////////////////////
// CPU ROM read translator
// Maps CPU reads through the banks and size mask
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rom_addr_map (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cpu_rd,
	input  mapper_pkg::cpu_addr_t  cpu_addr,
	output mapper_pkg::word_t      cpu_rdata,
	output logic                   cpu_ready,
	input  mapper_pkg::bank_file_t banks,
	input  mapper_pkg::rom_mask_t  rom_mask,
	rom_bus_if.client              read_bus
);
	import mapper_pkg::*;

	logic [2:0] bank_idx;
	mem_addr_t  mapped;
	logic       start;

	// cpu_addr index is console bit minus one
	assign bank_idx = cpu_addr[BANK_SEL_LSB+1:BANK_SEL_LSB-1];

	// Bank replaces bits 23..19, mask wraps small images
	assign mapped = {banks[bank_idx], cpu_addr[BANK_SEL_LSB-2:0]} & {rom_mask, 12'hfff};

	// cpu_rd stays up during the ready cycle
	assign start = cpu_rd & ~read_bus.req & ~cpu_ready;

	assign read_bus.we = 1'b0;
	assign read_bus.wdata = '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			read_bus.req <= 1'b0;
			cpu_ready <= 1'b0;
		end else begin
			cpu_ready <= 1'b0;
			if (read_bus.req) begin
				if (read_bus.ack) begin
					read_bus.req <= 1'b0;
					cpu_ready <= 1'b1; // One-cycle pulse
				end
			end else if (start) begin
				read_bus.req <= 1'b1;
			end
		end
	end

	// Address and returned word
	always_ff @(posedge clk_sys) begin
		if (start) begin
			read_bus.addr <= mapped;
		end
		if (read_bus.ack) begin
			cpu_rdata <= read_bus.rdata;
		end
	end

endmodule

`default_nettype wire

/* bank_regs.sv */
//////////////////////////////////////////////////
// Bank register set behind an APB slave
// Eight 5-bit banks, writable only on large ROMs
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module bank_regs (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [mapper_pkg::APB_ADDR_W-1:0]   paddr,
	input  mapper_pkg::bank_t                   pwdata,
	output mapper_pkg::bank_t                   prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  mapper_pkg::rom_mask_t               rom_mask,
	input  logic                                loading,
	output mapper_pkg::bank_file_t              banks
);
	import mapper_pkg::*;

	localparam int IDX_W = $clog2(NUM_BANKS);

	logic [IDX_W-1:0] idx;
	logic             access;
	logic             large_rom;
	logic             reject;
	logic             wr_ok;

	//////////////////////////////////////////////////
	// APB decode
	//////////////////////////////////////////////////
	assign idx = paddr[IDX_W:1]; // Word-aligned page registers
	assign access = psel & penable; // Access phase

	// Banking only makes sense past 4 MB
	assign large_rom = |(rom_mask & LARGE_ROM_BITS);

	// Bank 0 is fixed to keep the vectors in place
	assign reject = ~large_rom | (idx == '0) | loading;

	assign wr_ok = access & pwrite & ~reject;

	// Zero wait states
	assign pready = 1'b1;
	assign pslverr = access & pwrite & reject;

	// Readback is always allowed
	assign prdata = banks[idx];

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset || loading) begin
			banks <= identity_banks(); // Flat mapping during a download
		end else if (wr_ok) begin
			banks[idx] <= pwdata;
		end
	end

endmodule

`default_nettype wire

/* rom_loader.sv */
//////////////////////////////////////////////////
// ROM download loader
// Byte-swaps the 16-bit download into memory writes,
// stalls the host and learns the ROM size mask
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rom_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  logic [23:0]           dl_addr,
	input  mapper_pkg::word_t     dl_data,
	output logic                  dl_wait,
	rom_bus_if.client             load_bus,
	output mapper_pkg::rom_mask_t rom_mask,
	output logic                  loading
);

	logic pending; // Write waiting for its ack
	logic take;

	// Host only strobes while dl_wait is low
	assign take = dl_active & dl_wr & ~pending;

	assign dl_wait = pending;
	assign load_bus.req = pending;
	assign load_bus.we = 1'b1; // Loader only writes

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
			rom_mask <= '0;
			loading <= 1'b0;
		end else begin
			loading <= dl_active;

			if (take) begin
				pending <= 1'b1;
				// Word at address 0 starts a new image
				if (dl_addr == '0) begin
					rom_mask <= '0;
				end else begin
					rom_mask <= rom_mask | dl_addr[23:13];
				end
			end else if (load_bus.ack) begin
				pending <= 1'b0; // Host released next cycle
			end
		end
	end

	//////////////////////////////////////////////////
	// Write payload
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (take) begin
			load_bus.addr <= dl_addr[23:1]; // Byte to word address
			// Download stream is little endian
			load_bus.wdata <= {dl_data[7:0], dl_data[15:8]};
		end
	end

endmodule

`default_nettype wire

/* rom_bus_if.sv */
//////////////////////////////////////////////////
// Memory request bus between mapper clients and arbiter
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface rom_bus_if;
	import mapper_pkg::*;

	logic      req;   // Held until ack
	logic      we;    // 1 = write
	mem_addr_t addr;
	word_t     wdata;
	word_t     rdata; // Valid with ack
	logic      ack;   // One cycle

	// Requesting side
	modport client (
		output req,
		output we,
		output addr,
		output wdata,
		input  rdata,
		input  ack
	);

	// Arbiter side
	modport port (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output rdata,
		output ack
	);

endinterface

`default_nettype wire

/* mapper_pkg.sv */
//////////////////////////////////////////////////
// Cartridge mapper shared types and constants
// Widths follow the console 68k bus
//////////////////////////////////////////////////
`default_nettype none

package mapper_pkg;

	//////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////
	typedef logic [15:0] word_t;     // One bus data word
	typedef logic [22:0] cpu_addr_t; // Console address bits 23..1
	typedef logic [22:0] mem_addr_t; // External memory word address
	typedef logic [4:0]  bank_t;     // 512 KB bank number
	typedef logic [10:0] rom_mask_t; // Size mask over bits 23..13

	localparam int NUM_BANKS = 8;

	typedef bank_t [NUM_BANKS-1:0] bank_file_t;

	//////////////////////////////////////////////////
	// Mapper constants
	//////////////////////////////////////////////////
	// Lowest console address bit of the bank select field
	localparam int BANK_SEL_LSB = 19;

	// Mask bits 23..22, set once the ROM passes 4 MB
	localparam rom_mask_t LARGE_ROM_BITS = 11'b110_0000_0000;

	localparam int APB_ADDR_W = 4; // Page register window

	// Bank k maps to bank k
	function automatic bank_file_t identity_banks();
		bank_file_t b;
		for (int i = 0; i < NUM_BANKS; i++) begin
			b[i] = bank_t'(i);
		end
		return b;
	endfunction

endpackage

`default_nettype wire
